/* include/alu_consts.svh */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// register and datapath width
`define ALU_XLEN 64

// low bits of operand b used as shift amount
`define ALU_SHAMT_W 6

// one partial product per cycle
`define ALU_MUL_STEPS 64

// one quotient bit per cycle
// the sign fixup cycle comes on top of these
`define ALU_DIV_STEPS 64

`endif

/* hw/alu_ops_pkg.sv */
`default_nettype none

package alu_ops_pkg;

    // operation codes, numbered as the decoder sends them
    typedef enum logic [4:0] {
        ALU_ADD   = 5'd0,
        ALU_SUB   = 5'd1,
        ALU_RET_A = 5'd2,
        ALU_RET_B = 5'd3,
        ALU_XOR   = 5'd4,
        ALU_OR    = 5'd5,
        ALU_AND   = 5'd6,
        ALU_SLL   = 5'd7,
        ALU_SRL   = 5'd8,
        ALU_SLT   = 5'd9,
        ALU_SLTU  = 5'd10,
        ALU_MUL   = 5'd11,
        ALU_REM   = 5'd12,
        ALU_DIVU  = 5'd13,
        ALU_REMU  = 5'd14,
        ALU_DIV   = 5'd15,
        ALU_SRA   = 5'd16,
        ALU_EQ    = 5'd17,
        ALU_GE    = 5'd18,
        ALU_GEU   = 5'd19
    } alu_op_e;

    // operand a, anything but rs1 picks pc
    typedef enum logic [1:0] {
        SRC_A_PC  = 2'd0,
        SRC_A_RS1 = 2'd1
    } src_a_e;

    // operand b, unknown codes fall back to imm
    typedef enum logic [1:0] {
        SRC_B_IMM = 2'd0,
        SRC_B_RS2 = 2'd1,
        SRC_B_CSR = 2'd2
    } src_b_e;

endpackage

`default_nettype wire

/* hw/alu_data_pkg.sv */
`default_nettype none

`include "alu_consts.svh"

package alu_data_pkg;

    typedef struct packed {
        logic [`ALU_XLEN/2-1:0] hi;
        logic [`ALU_XLEN/2-1:0] lo;
    } alu_half_s;

    // one register word, seen whole or split for word mode
    typedef union packed {
        logic [`ALU_XLEN-1:0] full;
        alu_half_s            half;
    } alu_word_u;

    // what the divider hands back and how it treats signs
    typedef enum logic [1:0] {
        DM_DIV  = 2'd0,
        DM_DIVU = 2'd1,
        DM_REM  = 2'd2,
        DM_REMU = 2'd3
    } div_mode_e;

endpackage

`default_nettype wire

/* hw/seq_multiplier.sv */
`default_nettype none

`include "alu_consts.svh"

module seq_multiplier (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 start,
    input  logic [`ALU_XLEN-1:0] op_a,
    input  logic [`ALU_XLEN-1:0] op_b,
    output logic                 done,
    output logic [`ALU_XLEN-1:0] product
);

    localparam int CNT_W = $clog2(`ALU_MUL_STEPS);

    logic                 busy;
    logic [CNT_W-1:0]     step;
    logic                 last_step;
    logic [`ALU_XLEN-1:0] mcand;
    logic [`ALU_XLEN-1:0] mplier;
    logic [`ALU_XLEN-1:0] acc;
    logic [`ALU_XLEN-1:0] acc_next;

    // add the multiplicand when the current multiplier bit is set
    assign acc_next = mplier[0] ? acc + mcand : acc;

    assign last_step = busy && (step == CNT_W'(`ALU_MUL_STEPS - 1));

    // low word is exact for signed operands too, no fixup needed
    assign done    = last_step && !flush;
    assign product = acc_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            step <= '0;
        end else if (flush) begin
            busy <= 1'b0;
            step <= '0;
        end else if (start) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            busy <= !last_step;
            step <= step + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= op_a;
            mplier <= op_b;
            acc    <= '0;
        end else if (busy) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            acc    <= acc_next;
        end
    end

    // done is a single strobe per run
    assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done);

endmodule

`default_nettype wire

/* hw/seq_divider.sv */
`default_nettype none

`include "alu_consts.svh"

module seq_divider (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    start,
    input  alu_data_pkg::div_mode_e mode,
    input  logic [`ALU_XLEN-1:0]    dividend,
    input  logic [`ALU_XLEN-1:0]    divisor,
    output logic                    done,
    output logic [`ALU_XLEN-1:0]    result
);

    localparam int CNT_W = $clog2(`ALU_DIV_STEPS);
    localparam logic [`ALU_XLEN-1:0] MOST_NEG = {1'b1, {(`ALU_XLEN-1){1'b0}}};

    logic                    run;
    logic                    fix;
    logic [CNT_W-1:0]        step;
    logic                    last_step;
    logic                    signed_in;
    logic                    neg_a;
    logic                    neg_b;
    logic [`ALU_XLEN-1:0]    dvnd_mag;
    logic [`ALU_XLEN-1:0]    dvsr_mag;
    alu_data_pkg::div_mode_e mode_q;
    logic                    neg_a_q;
    logic                    neg_b_q;
    logic [`ALU_XLEN-1:0]    dvnd_q;
    logic [`ALU_XLEN-1:0]    dvsr_q;
    logic [`ALU_XLEN-1:0]    quo_q;
    logic [`ALU_XLEN-1:0]    rem_q;
    logic [`ALU_XLEN:0]      shifted;
    logic [`ALU_XLEN+1:0]    diff;
    logic                    is_rem;
    logic                    div_zero;
    logic                    overflow;
    logic [`ALU_XLEN-1:0]    quo_fix;
    logic [`ALU_XLEN-1:0]    rem_fix;

    // magnitudes for the signed modes
    assign signed_in = (mode == alu_data_pkg::DM_DIV) || (mode == alu_data_pkg::DM_REM);
    assign neg_a     = signed_in && dividend[`ALU_XLEN-1];
    assign neg_b     = signed_in && divisor[`ALU_XLEN-1];
    assign dvnd_mag  = neg_a ? -dividend : dividend;
    assign dvsr_mag  = neg_b ? -divisor : divisor;

    // restoring step, next dividend bit into the partial remainder
    assign shifted = {rem_q, quo_q[`ALU_XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvsr_q};

    assign last_step = run && (step == CNT_W'(`ALU_DIV_STEPS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run  <= 1'b0;
            fix  <= 1'b0;
            step <= '0;
        end else if (flush) begin
            run  <= 1'b0;
            fix  <= 1'b0;
            step <= '0;
        end else if (start) begin
            run  <= 1'b1;
            fix  <= 1'b0;
            step <= '0;
        end else if (run) begin
            run  <= !last_step;
            fix  <= last_step;
            step <= step + 1'b1;
        end else if (fix) begin
            fix <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mode_q  <= mode;
            neg_a_q <= neg_a;
            neg_b_q <= neg_b;
            dvnd_q  <= dividend;
            dvsr_q  <= dvsr_mag;
            quo_q   <= dvnd_mag;
            rem_q   <= '0;
        end else if (run) begin
            if (!diff[`ALU_XLEN+1]) begin
                rem_q <= diff[`ALU_XLEN-1:0];
                quo_q <= {quo_q[`ALU_XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[`ALU_XLEN-1:0];
                quo_q <= {quo_q[`ALU_XLEN-2:0], 1'b0};
            end
        end
    end

    assign is_rem   = (mode_q == alu_data_pkg::DM_REM) || (mode_q == alu_data_pkg::DM_REMU);
    assign div_zero = dvsr_q == '0;
    // most negative value over -1
    assign overflow = neg_a_q && neg_b_q && (dvnd_q == MOST_NEG) &&
                      (dvsr_q == `ALU_XLEN'(1));

    // fixup cycle, signs and the special cases
    always_comb begin
        if (div_zero) begin
            quo_fix = '1;
            rem_fix = dvnd_q;
        end else if (overflow) begin
            quo_fix = dvnd_q;
            rem_fix = '0;
        end else begin
            quo_fix = (neg_a_q ^ neg_b_q) ? -quo_q : quo_q;
            // remainder takes the sign of the dividend
            rem_fix = neg_a_q ? -rem_q : rem_q;
        end
    end

    assign done   = fix && !flush;
    assign result = is_rem ? rem_fix : quo_fix;

    // fixed latency, start to done
    assert property (@(posedge clk) disable iff (!arst_n || flush)
        start |-> ##(`ALU_DIV_STEPS + 1) done);

endmodule

`default_nettype wire

/* hw/alu_core.sv */
`default_nettype none

`include "alu_consts.svh"

module alu_core (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       flush,
    input  logic [`ALU_XLEN-1:0]       pc,
    input  alu_ops_pkg::alu_op_e       operate,
    input  logic [`ALU_XLEN-1:0]       rs1,
    input  logic [`ALU_XLEN-1:0]       rs2,
    input  logic [`ALU_XLEN-1:0]       csr,
    input  logic [`ALU_XLEN-1:0]       imm,
    input  alu_ops_pkg::src_a_e        sel_a,
    input  alu_ops_pkg::src_b_e        sel_b,
    input  logic                       rs1to32,
    input  logic                       mul_done,
    input  logic                       div_done,
    input  logic [`ALU_XLEN-1:0]       mul_res,
    input  logic [`ALU_XLEN-1:0]       div_res,
    output logic [`ALU_XLEN-1:0]       op_a,
    output logic [`ALU_XLEN-1:0]       op_b,
    output logic                       mul_start,
    output logic                       div_start,
    output alu_data_pkg::div_mode_e    div_mode,
    output logic [`ALU_XLEN-1:0]       res,
    output logic                       alu_wait
);

    alu_data_pkg::alu_word_u  rs1_word;
    alu_data_pkg::alu_word_u  a_word;
    logic [`ALU_XLEN-1:0]     rs1_eff;
    logic [`ALU_SHAMT_W-1:0]  shamt;
    logic [`ALU_XLEN-1:0]     sra_full;
    logic [`ALU_XLEN/2-1:0]   sra_lo;
    logic                     lt_s;
    logic                     lt_u;
    logic                     eq;
    logic                     is_mul;
    logic                     is_div;
    logic                     mul_busy;
    logic                     div_busy;

    // word mode keeps only the low half of rs1
    assign rs1_word.full = rs1;
    assign rs1_eff = rs1to32 ? {{(`ALU_XLEN/2){1'b0}}, rs1_word.half.lo} : rs1;

    assign op_a = (sel_a == alu_ops_pkg::SRC_A_RS1) ? rs1_eff : pc;
    assign op_b = (sel_b == alu_ops_pkg::SRC_B_RS2) ? rs2 :
                  (sel_b == alu_ops_pkg::SRC_B_CSR) ? csr : imm;

    assign shamt = op_b[`ALU_SHAMT_W-1:0];

    // arithmetic shifts, full word and low half
    assign a_word.full = op_a;
    assign sra_full = $signed(op_a) >>> shamt;
    assign sra_lo   = $signed(a_word.half.lo) >>> shamt;

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;
    assign eq   = op_a == op_b;

    assign is_mul = operate == alu_ops_pkg::ALU_MUL;
    assign is_div = operate inside {alu_ops_pkg::ALU_DIV, alu_ops_pkg::ALU_DIVU,
                                    alu_ops_pkg::ALU_REM, alu_ops_pkg::ALU_REMU};

    always_comb begin
        case (operate)
            alu_ops_pkg::ALU_DIVU: div_mode = alu_data_pkg::DM_DIVU;
            alu_ops_pkg::ALU_REM:  div_mode = alu_data_pkg::DM_REM;
            alu_ops_pkg::ALU_REMU: div_mode = alu_data_pkg::DM_REMU;
            default:               div_mode = alu_data_pkg::DM_DIV;
        endcase
    end

    // start only on the first cycle an op is presented
    assign mul_start = is_mul && !mul_busy && !flush;
    assign div_start = is_div && !div_busy && !flush;

    // hold the pipe until the unit reports done
    assign alu_wait = !flush && ((is_mul && !mul_done) || (is_div && !div_done));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mul_busy <= 1'b0;
            div_busy <= 1'b0;
        end else if (flush) begin
            mul_busy <= 1'b0;
            div_busy <= 1'b0;
        end else begin
            if (mul_start) begin
                mul_busy <= 1'b1;
            end else if (mul_done) begin
                mul_busy <= 1'b0;
            end
            if (div_start) begin
                div_busy <= 1'b1;
            end else if (div_done) begin
                div_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res <= '0;
        end else if (!flush) begin
            case (operate)
                alu_ops_pkg::ALU_ADD:   res <= op_a + op_b;
                alu_ops_pkg::ALU_SUB:   res <= op_a - op_b;
                alu_ops_pkg::ALU_RET_A: res <= op_a;
                alu_ops_pkg::ALU_RET_B: res <= op_b;
                alu_ops_pkg::ALU_XOR:   res <= op_a ^ op_b;
                alu_ops_pkg::ALU_OR:    res <= op_a | op_b;
                alu_ops_pkg::ALU_AND:   res <= op_a & op_b;
                alu_ops_pkg::ALU_SLL:   res <= op_a << shamt;
                alu_ops_pkg::ALU_SRL:   res <= op_a >> shamt;
                alu_ops_pkg::ALU_SLT:   res <= `ALU_XLEN'(lt_s);
                alu_ops_pkg::ALU_SLTU:  res <= `ALU_XLEN'(lt_u);
                alu_ops_pkg::ALU_EQ:    res <= `ALU_XLEN'(eq);
                alu_ops_pkg::ALU_GE:    res <= `ALU_XLEN'(!lt_s);
                alu_ops_pkg::ALU_GEU:   res <= `ALU_XLEN'(!lt_u);
                alu_ops_pkg::ALU_SRA: begin
                    res <= rs1to32 ? {{(`ALU_XLEN/2){1'b0}}, sra_lo} : sra_full;
                end
                alu_ops_pkg::ALU_MUL: begin
                    if (mul_done) begin
                        res <= mul_res;
                    end
                end
                alu_ops_pkg::ALU_DIV, alu_ops_pkg::ALU_DIVU,
                alu_ops_pkg::ALU_REM, alu_ops_pkg::ALU_REMU: begin
                    if (div_done) begin
                        res <= div_res;
                    end
                end
                default: res <= '0;
            endcase
        end
    end

    // no second start while the unit is still working
    assert property (@(posedge clk) disable iff (!arst_n || flush)
        mul_start |=> !mul_start [*`ALU_MUL_STEPS]);
    assert property (@(posedge clk) disable iff (!arst_n || flush)
        div_start |=> !div_start [*`ALU_DIV_STEPS + 1]);

    // flush frees the pipe and both units go quiet
    assert property (@(posedge clk) disable iff (!arst_n)
        flush |-> !alu_wait ##1 (!mul_done && !div_done));

endmodule

`default_nettype wire

/* hw/exec_unit.sv */
`default_nettype none

`include "alu_consts.svh"

module exec_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic [`ALU_XLEN-1:0] pc,
    input  alu_ops_pkg::alu_op_e operate,
    input  logic [`ALU_XLEN-1:0] rs1,
    input  logic [`ALU_XLEN-1:0] rs2,
    input  logic [`ALU_XLEN-1:0] csr,
    input  logic [`ALU_XLEN-1:0] imm,
    input  alu_ops_pkg::src_a_e  sel_a,
    input  alu_ops_pkg::src_b_e  sel_b,
    input  logic                 rs1to32,
    output logic [`ALU_XLEN-1:0] res,
    output logic                 alu_wait
);

    logic [`ALU_XLEN-1:0]    op_a;
    logic [`ALU_XLEN-1:0]    op_b;
    logic                    mul_start;
    logic                    mul_done;
    logic [`ALU_XLEN-1:0]    mul_res;
    logic                    div_start;
    logic                    div_done;
    logic [`ALU_XLEN-1:0]    div_res;
    alu_data_pkg::div_mode_e div_mode;

    alu_core u_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .pc        (pc),
        .operate   (operate),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .rs1to32   (rs1to32),
        .mul_done  (mul_done),
        .div_done  (div_done),
        .mul_res   (mul_res),
        .div_res   (div_res),
        .op_a      (op_a),
        .op_b      (op_b),
        .mul_start (mul_start),
        .div_start (div_start),
        .div_mode  (div_mode),
        .res       (res),
        .alu_wait  (alu_wait)
    );

    // both units share the selected operands
    seq_multiplier u_mul (
        .clk     (clk),
        .arst_n  (arst_n),
        .flush   (flush),
        .start   (mul_start),
        .op_a    (op_a),
        .op_b    (op_b),
        .done    (mul_done),
        .product (mul_res)
    );

    seq_divider u_div (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .start    (div_start),
        .mode     (div_mode),
        .dividend (op_a),
        .divisor  (op_b),
        .done     (div_done),
        .result   (div_res)
    );

endmodule

`default_nettype wire

/* bench/exec_unit_tb.sv */
`default_nettype none

`include "alu_consts.svh"

module exec_unit_tb;

    localparam int MAX_VEC = 64;
    localparam int NUM_COL = 11;

    // column order of the stim file
    localparam int C_OP  = 0;
    localparam int C_SA  = 1;
    localparam int C_SB  = 2;
    localparam int C_W   = 3;
    localparam int C_FL  = 4;
    localparam int C_PC  = 5;
    localparam int C_RS1 = 6;
    localparam int C_RS2 = 7;
    localparam int C_CSR = 8;
    localparam int C_IMM = 9;
    localparam int C_EXP = 10;

    logic                 clk;
    logic                 arst_n;
    logic                 flush;
    logic [`ALU_XLEN-1:0] pc;
    alu_ops_pkg::alu_op_e operate;
    logic [`ALU_XLEN-1:0] rs1;
    logic [`ALU_XLEN-1:0] rs2;
    logic [`ALU_XLEN-1:0] csr;
    logic [`ALU_XLEN-1:0] imm;
    alu_ops_pkg::src_a_e  sel_a;
    alu_ops_pkg::src_b_e  sel_b;
    logic                 rs1to32;
    logic [`ALU_XLEN-1:0] res;
    logic                 alu_wait;

    logic [`ALU_XLEN-1:0] vec_mem [0:MAX_VEC-1][0:NUM_COL-1];
    int                   vec_count;
    bit                   loaded;
    logic [`ALU_XLEN-1:0] last_res;
    int                   seed;
    int                   idle;

    exec_unit uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .pc       (pc),
        .operate  (operate),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr      (csr),
        .imm      (imm),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .rs1to32  (rs1to32),
        .res      (res),
        .alu_wait (alu_wait)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input logic [`ALU_XLEN-1:0] expv,
                                   input logic [`ALU_XLEN-1:0] got);
        $display("ERR %0t %s expected %h got %h", $time, what, expv, got);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    // mul, div, divu, rem and remu go through the sequential units
    function automatic bit is_multi(input logic [4:0] code);
        return code inside {alu_ops_pkg::ALU_MUL, alu_ops_pkg::ALU_DIV, alu_ops_pkg::ALU_DIVU,
                            alu_ops_pkg::ALU_REM, alu_ops_pkg::ALU_REMU};
    endfunction

    task automatic load_vectors();
        int               fd;
        int               n;
        logic [8*128-1:0] hdr;
        fd = $fopen("bench/alu_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/alu_stim.txt");
            $display("TEST FAILED");
            $fatal(1, "no stimulus");
        end else begin
            // skip the two column header lines
            n = $fgets(hdr, fd);
            n = $fgets(hdr, fd);
            vec_count = 0;
            n = NUM_COL;
            while (n == NUM_COL && vec_count < MAX_VEC) begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                            vec_mem[vec_count][0], vec_mem[vec_count][1],
                            vec_mem[vec_count][2], vec_mem[vec_count][3],
                            vec_mem[vec_count][4], vec_mem[vec_count][5],
                            vec_mem[vec_count][6], vec_mem[vec_count][7],
                            vec_mem[vec_count][8], vec_mem[vec_count][9],
                            vec_mem[vec_count][10]);
                if (n == NUM_COL) begin
                    vec_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    // bubble that rewrites res with its current value
    task automatic drive_idle();
        operate = alu_ops_pkg::ALU_RET_B;
        sel_a   = alu_ops_pkg::SRC_A_PC;
        sel_b   = alu_ops_pkg::SRC_B_IMM;
        rs1to32 = 1'b0;
        flush   = 1'b0;
        imm     = last_res;
    endtask

    // entered and left 1 unit after a rising edge
    task automatic run_vector(input int idx);
        bit multi;
        bit seen_wait;
        int flush_after;
        multi       = is_multi(vec_mem[idx][C_OP][4:0]);
        seen_wait   = 1'b0;
        flush_after = int'(vec_mem[idx][C_FL]);
        operate = alu_ops_pkg::alu_op_e'(vec_mem[idx][C_OP][4:0]);
        sel_a   = alu_ops_pkg::src_a_e'(vec_mem[idx][C_SA][1:0]);
        sel_b   = alu_ops_pkg::src_b_e'(vec_mem[idx][C_SB][1:0]);
        rs1to32 = vec_mem[idx][C_W][0];
        pc      = vec_mem[idx][C_PC];
        rs1     = vec_mem[idx][C_RS1];
        rs2     = vec_mem[idx][C_RS2];
        csr     = vec_mem[idx][C_CSR];
        imm     = vec_mem[idx][C_IMM];
        flush   = 1'b0;
        if (flush_after != 0) begin
            repeat (flush_after) begin
                @(negedge clk);
                if (alu_wait) begin
                    seen_wait = 1'b1;
                end
                @(posedge clk);
                #1;
            end
            flush = 1'b1;
            @(negedge clk);
            assert (!alu_wait)
            else report_mismatch($sformatf("vector %0d alu_wait in flush cycle", idx),
                                 '0, `ALU_XLEN'(alu_wait));
            @(posedge clk);
            #1;
        end else begin
            // hold everything until the unit reports done
            @(negedge clk);
            while (alu_wait) begin
                seen_wait = 1'b1;
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        assert (seen_wait == multi)
        else report_mismatch($sformatf("vector %0d alu_wait seen", idx),
                             `ALU_XLEN'(multi), `ALU_XLEN'(seen_wait));
        assert (res == vec_mem[idx][C_EXP])
        else report_mismatch($sformatf("vector %0d res", idx), vec_mem[idx][C_EXP], res);
        last_res = vec_mem[idx][C_EXP];
        drive_idle();
    endtask

    initial begin
        seed     = 65;
        loaded   = 1'b0;
        arst_n   = 1'b0;
        flush    = 1'b0;
        pc       = '0;
        rs1      = '0;
        rs2      = '0;
        csr      = '0;
        last_res = '0;
        drive_idle();
        load_vectors();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        assert (res == '0)
        else report_mismatch("res after reset", '0, res);
        assert (!alu_wait)
        else report_mismatch("alu_wait after reset", '0, `ALU_XLEN'(alu_wait));
        @(posedge clk);
        #1;
        for (int i = 0; i < vec_count; i++) begin
            run_vector(i);
            // 0 to 3 bubbles between vectors
            idle = $random(seed) & 3;
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
        end
        $display("TEST OK");
        $finish;
    end

    initial begin : watchdog
        longint limit;
        wait (loaded);
        limit = longint'(vec_count) * (`ALU_DIV_STEPS + 8) * 10;
        #(limit);
        $display("DUT hung, vectors did not finish within %0d time units", limit);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* bench/alu_stim.txt */
# op sel_a sel_b word flush_after pc rs1 rs2 csr imm expected (all hex)
# flush_after is the cycle count before flush is raised, 0 runs to completion
00 1 1 0 00 0 5 7 0 0 c
01 0 0 0 00 1000 0 0 0 1 fff
02 2 1 0 00 80000000 1234 0 0 0 80000000
03 1 2 0 00 0 0 0 deadbeef 0 deadbeef
03 1 3 0 00 0 0 77 99 55 55
04 1 1 0 00 0 ff00ff00 0ff00ff0 0 0 f0f0f0f0
05 1 2 0 00 0 f000 0 000f 0 f00f
06 1 0 0 00 0 123456789abcdef0 0 0 ff00ff00ff00ff00 120056009a00de00
07 1 0 0 00 0 1 0 0 43 8
08 1 1 0 00 0 8000000000000000 7f 0 0 1
10 1 0 0 00 0 8000000000000000 0 0 4 f800000000000000
10 1 0 1 00 0 ffffffff80000000 0 0 4 f8000000
00 1 1 1 00 0 ffffffff00000005 3 0 0 8
09 1 1 0 00 0 ffffffffffffffff 1 0 0 1
0a 1 1 0 00 0 ffffffffffffffff 1 0 0 0
11 1 0 0 00 0 42 0 0 42 1
12 1 1 0 00 0 ffffffffffffffff 1 0 0 0
13 1 1 0 00 0 ffffffffffffffff 1 0 0 1
1f 1 1 0 00 0 5 7 0 0 0
0b 1 1 0 00 0 ffffffffffffffff 3 0 0 fffffffffffffffd
0b 1 1 0 00 0 100000001 100000001 0 0 200000001
0f 1 1 0 00 0 fffffffffffffff9 2 0 0 fffffffffffffffd
0c 1 1 0 00 0 fffffffffffffff9 2 0 0 ffffffffffffffff
0d 1 1 0 00 0 fffffffffffffff9 2 0 0 7ffffffffffffffc
0e 1 1 0 00 0 fffffffffffffff9 2 0 0 1
0f 1 1 0 00 0 1234 0 0 0 ffffffffffffffff
0c 1 1 0 00 0 1234 0 0 0 1234
0f 1 1 0 1e 0 64 5 0 0 1234
0c 1 1 0 00 0 8000000000000000 ffffffffffffffff 0 0 0
0f 1 1 0 00 0 8000000000000000 ffffffffffffffff 0 0 8000000000000000
0b 1 1 0 0a 0 ffff ffff 0 0 8000000000000000
0b 1 1 0 00 0 7 6 0 0 2a

/* list.f */
+incdir+include
hw/alu_ops_pkg.sv
hw/alu_data_pkg.sv
hw/seq_multiplier.sv
hw/seq_divider.sv
hw/alu_core.sv
hw/exec_unit.sv
bench/exec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the exec_unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module exec_unit_tb -o exec_unit_sim &&
./obj_dir/exec_unit_sim | tee /dev/stderr | grep -q "TEST OK" &&
echo "exec_unit simulation passed" ||
{ echo "exec_unit simulation failed"; exit 1; }
